// File: gamepad_subsystem.f
logic/gamepad_pkg.sv
logic/esp32_spi_frame_decoder.sv
logic/pad_state_regs.sv
logic/pad_serial_emulator.sv
logic/esp32_link_control.sv
logic/gamepad_subsystem.sv
verification/tb_gamepad_subsystem.sv

// File: logic/esp32_link_control.sv
// ----------------------------------------
// Debounces the board button that resets the ESP32
// esp32_en is low while the button is held
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module esp32_link_control #(
    parameter int unsigned DEBOUNCE_CYCLES = 1000000
) (
    input  logic clk_2x,
    input  logic rst,

    input  logic user_btn,
    output logic esp32_en
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

    logic [1:0]       btn_sync;
    logic             btn_s;
    logic             btn_level;
    logic [CNT_W-1:0] stable_cnt;

    always_ff @(posedge clk_2x) begin
        if (rst) begin
            btn_sync <= 2'b00;
        end else begin
            btn_sync <= {btn_sync[0], user_btn};
        end
    end

    assign btn_s = btn_sync[1];

    // Count cycles the input has differed from the debounced level
    always_ff @(posedge clk_2x) begin
        if (rst) begin
            btn_level <= 1'b0;
            stable_cnt <= '0;
        end else if (btn_s == btn_level) begin
            stable_cnt <= '0;
        end else if (stable_cnt == CNT_LAST) begin
            btn_level <= btn_s;
            stable_cnt <= '0;
        end else begin
            stable_cnt <= stable_cnt + CNT_W'(1);
        end
    end

    // Pressed button holds the ESP32 in reset
    assign esp32_en = ~btn_level;

endmodule

`default_nettype wire

// File: logic/esp32_spi_frame_decoder.sv
// ----------------------------------------
// Decodes SPI button frames from the ESP32
// Mode 0, MSB first; the frame ends when csn rises
// Emits an update strobe or a frame error pulse
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module esp32_spi_frame_decoder
    import gamepad_pkg::*;
(
    input  logic        clk_2x,
    input  logic        rst,

    input  logic        spi_csn,
    input  logic        spi_clk,
    input  logic        spi_mosi,

    output pad_update_t update,
    output logic        update_valid,
    output logic        frame_error
);

    localparam logic [2:0] FRAME_COUNT = 3'(FRAME_BYTES);
    localparam logic [2:0] COUNT_MAX = 3'd7;

    // Synchronizers, csn idles high
    logic [1:0] csn_sync;
    logic [1:0] clk_sync;
    logic [1:0] mosi_sync;
    logic       csn_prev;
    logic       clk_prev;

    logic       csn_active;
    logic       csn_rise;
    logic       clk_rise;
    logic       mosi_s;

    logic [6:0] shift_reg;
    logic [7:0] next_byte;
    logic [2:0] bit_cnt;
    logic [2:0] byte_cnt;

    pad_cmd_e     opcode_reg;
    pad_buttons_t buttons_reg;

    logic frame_ok;
    logic opcode_ok;
    logic player_sel;

    always_ff @(posedge clk_2x) begin
        if (rst) begin
            csn_sync <= 2'b11;
            clk_sync <= 2'b00;
            csn_prev <= 1'b1;
            clk_prev <= 1'b0;
        end else begin
            csn_sync <= {csn_sync[0], spi_csn};
            clk_sync <= {clk_sync[0], spi_clk};
            csn_prev <= csn_sync[1];
            clk_prev <= clk_sync[1];
        end
    end

    always_ff @(posedge clk_2x) begin
        mosi_sync <= {mosi_sync[0], spi_mosi};
    end

    assign mosi_s = mosi_sync[1];
    assign csn_active = ~csn_sync[1];
    assign csn_rise = csn_sync[1] & ~csn_prev;
    assign clk_rise = clk_sync[1] & ~clk_prev;
    assign next_byte = {shift_reg, mosi_s};

    // Counters clear while deselected; the byte count saturates
    always_ff @(posedge clk_2x) begin
        if (rst || !csn_active) begin
            bit_cnt <= 3'd0;
            byte_cnt <= 3'd0;
        end else if (clk_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7 && byte_cnt != COUNT_MAX) begin
                byte_cnt <= byte_cnt + 3'd1;
            end
        end
    end

    // Byte assembly and field capture
    always_ff @(posedge clk_2x) begin
        if (csn_active && clk_rise) begin
            shift_reg <= next_byte[6:0];
            if (bit_cnt == 3'd7) begin
                case (byte_cnt)
                    3'd0: opcode_reg <= pad_cmd_e'(next_byte);
                    3'd1: buttons_reg[PAD_BUTTON_COUNT-1:8] <= next_byte[3:0];
                    3'd2: buttons_reg[7:0] <= next_byte;
                    default: ;
                endcase
            end
        end
    end

    // Frame checks, read at the csn rising edge
    always_comb begin
        frame_ok = (byte_cnt == FRAME_COUNT) && (bit_cnt == 3'd0);
        opcode_ok = 1'b0;
        player_sel = 1'b0;
        case (opcode_reg)
            CMD_SET_P1: opcode_ok = 1'b1;
            CMD_SET_P2: begin
                opcode_ok = 1'b1;
                player_sel = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_2x) begin
        if (rst) begin
            update_valid <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            update_valid <= csn_rise && frame_ok && opcode_ok;
            frame_error <= csn_rise && !(frame_ok && opcode_ok);
        end
    end

    always_ff @(posedge clk_2x) begin
        if (csn_rise) begin
            update.player <= player_sel;
            update.buttons <= buttons_reg;
        end
    end

endmodule

`default_nettype wire

// File: logic/gamepad_pkg.sv
// ----------------------------------------
// Shared definitions for the gamepad input path
// Modules take these by a wildcard import
// ----------------------------------------

`default_nettype none

package gamepad_pkg;

    // Buttons per player and bits per serial read
    localparam int PAD_BUTTON_COUNT = 12;
    localparam int PAD_READ_BITS = 16;

    // Opcode, high button nibble, low button byte
    localparam int FRAME_BYTES = 3;

    // First byte of a frame from the microcontroller
    typedef enum logic [7:0] {
        CMD_SET_P1 = 8'h01,
        CMD_SET_P2 = 8'h02
    } pad_cmd_e;

    // Active high, bit 0 = B
    // B, Y, SELECT, START, UP, DOWN, LEFT, RIGHT, A, X, L, R
    typedef logic [PAD_BUTTON_COUNT-1:0] pad_buttons_t;

    // One decoded update, player 0 = P1
    typedef struct packed {
        logic         player;
        pad_buttons_t buttons;
    } pad_update_t;

endpackage

`default_nettype wire

// File: logic/gamepad_subsystem.sv
// ----------------------------------------
// Gamepad input path top level
// ESP32 SPI frames in, serial pad reads out
// Also debounces the ESP32 reset button
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module gamepad_subsystem
    import gamepad_pkg::*;
#(
    parameter int unsigned DEBOUNCE_CYCLES = 1000000
) (
    input  logic         clk_2x,
    input  logic         rst,

    // ESP32 link
    input  logic         spi_csn,
    input  logic         spi_clk,
    input  logic         spi_mosi,
    input  logic         user_btn,
    output logic         esp32_en,

    // Console pad bus
    input  logic         pad_latch,
    input  logic         pad_clk,
    output logic [1:0]   pad_data,

    // Status
    output pad_buttons_t status_btn,
    output logic         frame_error
);

    pad_update_t  update;
    logic         update_valid;
    pad_buttons_t pad_p1;
    pad_buttons_t pad_p2;

    esp32_spi_frame_decoder esp32_spi_frame_decoder_inst (
        .clk_2x(clk_2x),
        .rst(rst),
        .spi_csn(spi_csn),
        .spi_clk(spi_clk),
        .spi_mosi(spi_mosi),
        .update(update),
        .update_valid(update_valid),
        .frame_error(frame_error)
    );

    pad_state_regs pad_state_regs_inst (
        .clk_2x(clk_2x),
        .rst(rst),
        .update(update),
        .update_valid(update_valid),
        .pad_p1(pad_p1),
        .pad_p2(pad_p2)
    );

    pad_serial_emulator pad_serial_emulator_inst (
        .clk_2x(clk_2x),
        .rst(rst),
        .pad_p1(pad_p1),
        .pad_p2(pad_p2),
        .pad_latch(pad_latch),
        .pad_clk(pad_clk),
        .pad_data(pad_data)
    );

    esp32_link_control #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) esp32_link_control_inst (
        .clk_2x(clk_2x),
        .rst(rst),
        .user_btn(user_btn),
        .esp32_en(esp32_en)
    );

    // P1 buttons also drive the board LEDs
    assign status_btn = pad_p1;

endmodule

`default_nettype wire

// File: logic/pad_serial_emulator.sv
// ----------------------------------------
// Emulates two serial pads on the latch/clock bus
// Latch takes a snapshot, each pad_clk edge shifts one bit
// Outputs are active low, bit 0 (B) first
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module pad_serial_emulator
    import gamepad_pkg::*;
(
    input  logic         clk_2x,
    input  logic         rst,

    input  pad_buttons_t pad_p1,
    input  pad_buttons_t pad_p2,

    input  logic         pad_latch,
    input  logic         pad_clk,
    output logic [1:0]   pad_data
);

    localparam int PAD_SPARE_BITS = PAD_READ_BITS - PAD_BUTTON_COUNT;

    logic [PAD_READ_BITS-1:0] shift_p1;
    logic [PAD_READ_BITS-1:0] shift_p2;
    logic                     pad_clk_prev;
    logic                     pad_clk_rise;

    assign pad_clk_rise = pad_clk & ~pad_clk_prev;

    // Snapshot stays fixed for the rest of a read
    always_ff @(posedge clk_2x) begin
        if (rst) begin
            pad_clk_prev <= 1'b0;
            shift_p1 <= '0;
            shift_p2 <= '0;
        end else begin
            pad_clk_prev <= pad_clk;
            if (pad_latch) begin
                shift_p1 <= {{PAD_SPARE_BITS{1'b0}}, pad_p1};
                shift_p2 <= {{PAD_SPARE_BITS{1'b0}}, pad_p2};
            end else if (pad_clk_rise) begin
                // Released bits fill in behind the stream
                shift_p1 <= {1'b0, shift_p1[PAD_READ_BITS-1:1]};
                shift_p2 <= {1'b0, shift_p2[PAD_READ_BITS-1:1]};
            end
        end
    end

    // Registered pin outputs, released when idle
    always_ff @(posedge clk_2x) begin
        if (rst) begin
            pad_data <= 2'b11;
        end else begin
            pad_data <= {~shift_p2[0], ~shift_p1[0]};
        end
    end

endmodule

`default_nettype wire

// File: logic/pad_state_regs.sv
// ----------------------------------------
// Button state of both players
// Written by decoded SPI updates, read by the pad emulator
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module pad_state_regs
    import gamepad_pkg::*;
(
    input  logic         clk_2x,
    input  logic         rst,

    input  pad_update_t  update,
    input  logic         update_valid,

    output pad_buttons_t pad_p1,
    output pad_buttons_t pad_p2
);

    // Player 1
    always_ff @(posedge clk_2x) begin
        if (rst) begin
            pad_p1 <= '0;
        end else if (update_valid && !update.player) begin
            pad_p1 <= update.buttons;
        end
    end

    // Player 2
    always_ff @(posedge clk_2x) begin
        if (rst) begin
            pad_p2 <= '0;
        end else if (update_valid && update.player) begin
            pad_p2 <= update.buttons;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the gamepad subsystem testbench with Verilator and runs it.
# Exits non-zero unless the run reports a pass.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator was not found in PATH"
    exit 1
fi

verilator --binary --timing -j 0 \
    --top-module tb_gamepad_subsystem \
    --Mdir obj_dir \
    -f gamepad_subsystem.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_gamepad_subsystem)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

// File: verification/tb_gamepad_subsystem.sv
// ----------------------------------------
// Directed testbench for the gamepad subsystem
// Sends SPI frames, performs pad reads and
// presses the ESP32 reset button
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_gamepad_subsystem
    import gamepad_pkg::*;
();

    localparam int DEBOUNCE = 20;
    localparam int SPI_HALF = 4;
    localparam int TIMEOUT_CYCLES = 20000;

    logic         clk_2x;
    logic         rst;
    logic         spi_csn;
    logic         spi_clk;
    logic         spi_mosi;
    logic         user_btn;
    logic         pad_latch;
    logic         pad_clk;
    logic [1:0]   pad_data;
    pad_buttons_t status_btn;
    logic         frame_error;
    logic         esp32_en;

    int error_count = 0;
    int error_pulses = 0;
    int expected_pulses = 0;
    int cycle_count = 0;

    logic [7:0]               tx_bytes [$];
    logic [PAD_READ_BITS-1:0] read_p1;
    logic [PAD_READ_BITS-1:0] read_p2;
    pad_buttons_t             p1_model;
    pad_buttons_t             p2_model;

    gamepad_subsystem #(
        .DEBOUNCE_CYCLES(DEBOUNCE)
    ) gamepad_subsystem_inst (
        .clk_2x(clk_2x),
        .rst(rst),
        .spi_csn(spi_csn),
        .spi_clk(spi_clk),
        .spi_mosi(spi_mosi),
        .user_btn(user_btn),
        .esp32_en(esp32_en),
        .pad_latch(pad_latch),
        .pad_clk(pad_clk),
        .pad_data(pad_data),
        .status_btn(status_btn),
        .frame_error(frame_error)
    );

    initial begin
        clk_2x = 1'b0;
        forever #2 clk_2x = ~clk_2x;
    end

    // Error pulses are one cycle wide
    always @(negedge clk_2x) begin
        if (frame_error === 1'b1) begin
            error_pulses++;
        end
    end

    always @(posedge clk_2x) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk_2x);
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s (got %0h, expected %0h)", $time, msg, actual, expected);
            error_count++;
        end
    endtask

    // Serial stream as the console sees it, active low with spare bits released
    function automatic logic [PAD_READ_BITS-1:0] pad_stream(input pad_buttons_t buttons);
        return {{(PAD_READ_BITS - PAD_BUTTON_COUNT){1'b1}}, ~buttons};
    endfunction

    function automatic pad_buttons_t random_buttons(input pad_buttons_t avoid);
        pad_buttons_t value;
        value = pad_buttons_t'($urandom);
        if (value == avoid) begin
            value = ~value;
        end
        return value;
    endfunction

    // Mode 0, data set up while spi_clk is low
    task automatic send_bit(input logic value);
        spi_mosi = value;
        wait_cycles(SPI_HALF);
        spi_clk = 1'b1;
        wait_cycles(SPI_HALF);
        spi_clk = 1'b0;
    endtask

    task automatic send_frame(input int extra_bits);
        spi_csn = 1'b0;
        wait_cycles(SPI_HALF);
        foreach (tx_bytes[i]) begin
            for (int b = 7; b >= 0; b--) begin
                send_bit(tx_bytes[i][b]);
            end
        end
        for (int b = 0; b < extra_bits; b++) begin
            send_bit(b[0]);
        end
        wait_cycles(SPI_HALF);
        spi_csn = 1'b1;
        // Decoder result lands 3 or 4 cycles after csn rises
        wait_cycles(8);
    endtask

    task automatic send_update(input logic [7:0] opcode, input pad_buttons_t buttons);
        tx_bytes.delete();
        tx_bytes.push_back(opcode);
        tx_bytes.push_back({4'hA, buttons[11:8]});
        tx_bytes.push_back(buttons[7:0]);
        send_frame(0);
    endtask

    task automatic read_pad();
        pad_latch = 1'b1;
        wait_cycles(2);
        pad_latch = 1'b0;
        wait_cycles(2);
        // Bit 0 arrives first and ends up at the bottom
        for (int i = 0; i < PAD_READ_BITS; i++) begin
            read_p1 = {pad_data[0], read_p1[PAD_READ_BITS-1:1]};
            read_p2 = {pad_data[1], read_p2[PAD_READ_BITS-1:1]};
            pad_clk = 1'b1;
            wait_cycles(2);
            pad_clk = 1'b0;
            wait_cycles(2);
        end
        check_equal(32'(pad_data), 32'h3, "pad_data released after 16 shifts");
    endtask

    task automatic read_and_check(input string label);
        read_pad();
        check_equal(32'(read_p1), 32'(pad_stream(p1_model)), {label, ": P1 read"});
        check_equal(32'(read_p2), 32'(pad_stream(p2_model)), {label, ": P2 read"});
        check_equal(32'(status_btn), 32'(p1_model), {label, ": status_btn"});
    endtask

    task automatic check_reset_state();
        read_and_check("after reset");
        check_equal(32'(esp32_en), 32'h1, "esp32_en high after reset");
    endtask

    task automatic p1_update();
        p1_model = random_buttons(p1_model);
        send_update(CMD_SET_P1, p1_model);
        read_and_check("P1 update");
    endtask

    task automatic p2_update_and_replace();
        p2_model = random_buttons(p2_model);
        send_update(CMD_SET_P2, p2_model);
        read_and_check("P2 update");
        p1_model = random_buttons(p1_model);
        send_update(CMD_SET_P1, p1_model);
        read_and_check("P1 replaced");
    endtask

    task automatic reject_malformed_frames();
        pad_buttons_t bad;
        bad = ~p1_model;
        tx_bytes.delete();
        tx_bytes.push_back(CMD_SET_P1);
        tx_bytes.push_back({4'h0, bad[11:8]});
        send_frame(0);
        tx_bytes.push_back(bad[7:0]);
        tx_bytes.push_back(8'h00);
        send_frame(0);
        void'(tx_bytes.pop_back());
        send_frame(3);
        // Unknown opcode with otherwise well formed bytes
        tx_bytes[0] = 8'h05;
        send_frame(0);
        expected_pulses += 4;
        check_equal(32'(error_pulses), 32'(expected_pulses), "frame_error pulses, bad frames");
        read_and_check("after malformed frames");
    endtask

    task automatic update_during_read();
        pad_buttons_t old_p1;
        pad_buttons_t new_p1;
        old_p1 = p1_model;
        new_p1 = random_buttons(old_p1);
        fork
            send_update(CMD_SET_P1, new_p1);
            begin
                // Latch lands about 20 cycles before the frame ends
                wait_cycles(180);
                check_equal(32'(status_btn), 32'(old_p1), "P1 unchanged at latch");
                read_pad();
                check_equal(32'(status_btn), 32'(new_p1), "P1 updated during read");
            end
        join
        check_equal(32'(read_p1), 32'(pad_stream(old_p1)), "read in progress keeps snapshot");
        p1_model = new_p1;
        read_and_check("read after mid-read update");
    endtask

    task automatic debounce_button();
        logic dropped;
        dropped = 1'b0;
        user_btn = 1'b1;
        repeat (DEBOUNCE / 2) begin
            wait_cycles(1);
            dropped = dropped | ~esp32_en;
        end
        user_btn = 1'b0;
        repeat (DEBOUNCE * 2) begin
            wait_cycles(1);
            dropped = dropped | ~esp32_en;
        end
        check_equal(32'(dropped), 32'h0, "short press leaves esp32_en high");
        user_btn = 1'b1;
        wait_cycles(DEBOUNCE + 6);
        check_equal(32'(esp32_en), 32'h0, "held press drives esp32_en low");
        user_btn = 1'b0;
        wait_cycles(DEBOUNCE + 6);
        check_equal(32'(esp32_en), 32'h1, "held release returns esp32_en high");
    endtask

    initial begin
        void'($urandom(33));
        rst = 1'b1;
        spi_csn = 1'b1;
        spi_clk = 1'b0;
        spi_mosi = 1'b0;
        user_btn = 1'b0;
        pad_latch = 1'b0;
        pad_clk = 1'b0;
        p1_model = '0;
        p2_model = '0;
        repeat (10) @(posedge clk_2x);
        @(negedge clk_2x);
        rst = 1'b0;
        wait_cycles(4);

        check_reset_state();
        p1_update();
        p2_update_and_replace();
        reject_malformed_frames();
        update_during_read();
        debounce_button();

        check_equal(32'(error_pulses), 32'(expected_pulses), "total frame_error pulses");
        $display("Errors: %0d, frame_error pulses: %0d of %0d expected",
                 error_count, error_pulses, expected_pulses);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
